/* Bender.yml */
package:
  name: mmu_load_unit

sources:
  - files:
      - common/mmu_geom_pkg.sv
      - common/mmu_regmap_pkg.sv
      - src/job_regfile.sv
      - memory_scheduler/x_tile_tracker.sv
      - memory_scheduler/memory_scheduler.sv
      - src/stream_addr_gen.sv
      - src/mmu_load_unit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_mmu_load_unit.sv

/* all.f */
+incdir+tb
common/mmu_geom_pkg.sv
common/mmu_regmap_pkg.sv
src/job_regfile.sv
memory_scheduler/x_tile_tracker.sv
memory_scheduler/memory_scheduler.sv
src/stream_addr_gen.sv
src/mmu_load_unit.sv
tb/tb_mmu_load_unit.sv

/* common/mmu_geom_pkg.sv */
/*
 * Matrix-multiply load unit geometry
 * Array size, address and count widths, tile step
 */
`default_nettype none

package mmu_geom_pkg;

  localparam int unsigned ARRAY_W = 8;
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned CNT_W   = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // Byte step between X column tiles and between W or Z lines
  localparam addr_t TILE_JMP = addr_t'(32);

  // Streams are x, w, y and z
  localparam int unsigned NUM_STREAMS = 4;

endpackage

`default_nettype wire

/* common/mmu_regmap_pkg.sv */
/*
 * Job register map of the load unit
 * Register indices and field positions inside the job words
 */
`default_nettype none

package mmu_regmap_pkg;

  localparam int unsigned NUM_REGS = 14;

  typedef logic [3:0] reg_idx_t;

  localparam reg_idx_t X_ADDR       = 4'd0;
  localparam reg_idx_t W_ADDR       = 4'd1;
  localparam reg_idx_t Z_ADDR       = 4'd2;
  localparam reg_idx_t X_ITERS      = 4'd3;
  localparam reg_idx_t W_ITERS      = 4'd4;
  localparam reg_idx_t LEFTOVERS    = 4'd5;
  localparam reg_idx_t TOT_X_READ   = 4'd6;
  localparam reg_idx_t X_ROWS_OFFS  = 4'd7;
  localparam reg_idx_t X_D1_STRIDE  = 4'd8;
  localparam reg_idx_t W_TOT_LEN    = 4'd9;
  localparam reg_idx_t W_D0_STRIDE  = 4'd10;
  localparam reg_idx_t Z_TOT_LEN    = 4'd11;
  localparam reg_idx_t Z_D0_STRIDE  = 4'd12;
  localparam reg_idx_t OP_SELECTION = 4'd13;

  // Rows high and columns low in X_ITERS
  // D0 length high and passes low in W_ITERS
  localparam int unsigned ITERS_HI_LSB = 16;
  localparam int unsigned ITERS_LO_LSB = 0;

  // Rows in the last X row tile or zero for a full tile
  localparam int unsigned LEFT_ROWS_LSB = 24;
  localparam int unsigned LEFT_ROWS_W   = 8;

  localparam int unsigned OP_Y_ACC_BIT = 0;

endpackage

`default_nettype wire

/* memory_scheduler/memory_scheduler.sv */
/*
 * Memory scheduler
 * Sequences one job and issues start requests with geometry
 * to the X, W, Y and Z address generators
 */
`timescale 1ns/1ps
`default_nettype none

module memory_scheduler
  import mmu_geom_pkg::*;
  import mmu_regmap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        start_i,
  output logic        busy_o,
  output logic        done_o,
  input  logic [31:0] x_addr_i,
  input  logic [31:0] w_addr_i,
  input  logic [31:0] z_addr_i,
  input  logic [31:0] x_iters_i,
  input  logic [31:0] w_iters_i,
  input  logic [31:0] leftovers_i,
  input  logic [31:0] tot_x_read_i,
  input  logic [31:0] x_rows_offs_i,
  input  logic [31:0] x_d1_stride_i,
  input  logic [31:0] w_tot_len_i,
  input  logic [31:0] w_d0_stride_i,
  input  logic [31:0] z_tot_len_i,
  input  logic [31:0] z_d0_stride_i,
  input  logic [31:0] op_sel_i,
  input  logic        x_ready_i,
  input  logic        w_ready_i,
  input  logic        y_ready_i,
  input  logic        z_ready_i,
  input  logic        x_done_i,
  input  logic        w_done_i,
  input  logic        y_done_i,
  input  logic        z_done_i,
  output logic        x_req_start_o,
  output addr_t       x_base_o,
  output cnt_t        x_tot_len_o,
  output cnt_t        x_d0_len_o,
  output addr_t       x_d0_stride_o,
  output addr_t       x_d1_stride_o,
  output logic        w_req_start_o,
  output addr_t       w_base_o,
  output cnt_t        w_tot_len_o,
  output cnt_t        w_d0_len_o,
  output addr_t       w_d0_stride_o,
  output addr_t       w_d1_stride_o,
  output logic        y_req_start_o,
  output addr_t       y_base_o,
  output cnt_t        y_tot_len_o,
  output cnt_t        y_d0_len_o,
  output addr_t       y_d0_stride_o,
  output addr_t       y_d1_stride_o,
  output logic        z_req_start_o,
  output addr_t       z_base_o,
  output cnt_t        z_tot_len_o,
  output cnt_t        z_d0_len_o,
  output addr_t       z_d0_stride_o,
  output addr_t       z_d1_stride_o
);

  logic                   busy_q, first_load_q;
  logic [NUM_STREAMS-1:0] outst_q, fire, dones;
  logic                   start_acc, y_en, first_issued;
  addr_t                  x_offset;
  cnt_t                   x_reads, x_done_cnt, tot_x;

  assign start_acc = start_i && !busy_q;
  assign y_en      = op_sel_i[OP_Y_ACC_BIT];
  assign tot_x     = tot_x_read_i[CNT_W-1:0];

  x_tile_tracker i_x_tile_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (start_acc),
    .x_done_i       (x_done_i),
    .x_cols_i       (x_iters_i[ITERS_LO_LSB +: CNT_W]),
    .x_rows_i       (x_iters_i[ITERS_HI_LSB +: CNT_W]),
    .w_passes_i     (w_iters_i[ITERS_LO_LSB +: CNT_W]),
    .x_rows_offs_i  (x_rows_offs_i),
    .leftover_rows_i(leftovers_i[LEFT_ROWS_LSB +: LEFT_ROWS_W]),
    .x_offset_o     (x_offset),
    .x_reads_o      (x_reads),
    .tot_x_read_o   (x_done_cnt)
  );

  // W, Z and optional Y load once at job start
  assign w_req_start_o = first_load_q && w_ready_i;
  assign z_req_start_o = first_load_q && z_ready_i;
  assign y_req_start_o = first_load_q && y_en && y_ready_i;
  assign first_issued  = w_ready_i && z_ready_i && (y_ready_i || !y_en);

  // Next X burst waits one cycle after done so that the new offset is in place
  assign x_req_start_o = busy_q && x_ready_i && !x_done_i &&
                         (first_load_q || x_done_cnt <= tot_x);

  assign fire  = {z_req_start_o, y_req_start_o, w_req_start_o, x_req_start_o};
  assign dones = {z_done_i, y_done_i, w_done_i, x_done_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      first_load_q <= 1'b0;
      outst_q      <= '0;
    end else if (start_acc) begin
      busy_q       <= 1'b1;
      first_load_q <= 1'b1;
      outst_q      <= '0;
    end else begin
      outst_q <= (outst_q & ~dones) | fire;
      if (first_load_q && first_issued) begin
        first_load_q <= 1'b0;
      end
      if (done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // All bursts issued and every started stream has drained
  assign done_o = busy_q && !first_load_q && (outst_q == '0) && (x_done_cnt > tot_x);
  assign busy_o = busy_q;

  assign x_base_o      = x_addr_i + x_offset;
  assign x_tot_len_o   = x_reads;
  assign x_d0_len_o    = cnt_t'(1);
  assign x_d0_stride_o = '0;
  assign x_d1_stride_o = x_d1_stride_i;

  assign w_base_o      = w_addr_i;
  assign w_tot_len_o   = w_tot_len_i[CNT_W-1:0];
  assign w_d0_len_o    = w_iters_i[ITERS_HI_LSB +: CNT_W];
  assign w_d0_stride_o = w_d0_stride_i;
  assign w_d1_stride_o = TILE_JMP;

  assign y_base_o      = z_addr_i;
  assign y_tot_len_o   = z_tot_len_i[CNT_W-1:0];
  assign y_d0_len_o    = cnt_t'(ARRAY_W);
  assign y_d0_stride_o = z_d0_stride_i;
  assign y_d1_stride_o = TILE_JMP;

  assign z_base_o      = z_addr_i;
  assign z_tot_len_o   = z_tot_len_i[CNT_W-1:0];
  assign z_d0_len_o    = cnt_t'(ARRAY_W);
  assign z_d0_stride_o = z_d0_stride_i;
  assign z_d1_stride_o = TILE_JMP;

endmodule

`default_nettype wire

/* memory_scheduler/x_tile_tracker.sv */
/*
 * X tile tracker
 * Walks columns, W passes and row tiles of the X operand and
 * keeps the byte offset of the next X burst
 */
`timescale 1ns/1ps
`default_nettype none

module x_tile_tracker
  import mmu_geom_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       x_done_i,
  input  cnt_t       x_cols_i,
  input  cnt_t       x_rows_i,
  input  cnt_t       w_passes_i,
  input  addr_t      x_rows_offs_i,
  input  logic [7:0] leftover_rows_i,
  output addr_t      x_offset_o,
  output cnt_t       x_reads_o,
  output cnt_t       tot_x_read_o
);

  cnt_t  col_q, pass_q, row_q, tot_q;
  addr_t col_offs_q, row_offs_q;
  logic  col_last, pass_last, row_last;

  assign col_last  = (col_q == x_cols_i - 1'b1);
  assign pass_last = (pass_q == w_passes_i - 1'b1);
  assign row_last  = (row_q == x_rows_i - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q      <= '0;
      pass_q     <= '0;
      row_q      <= '0;
      tot_q      <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (clear_i) begin
      col_q      <= '0;
      pass_q     <= '0;
      row_q      <= '0;
      tot_q      <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
    end else if (x_done_i) begin
      tot_q <= tot_q + 1'b1;
      if (col_last) begin
        col_q      <= '0;
        col_offs_q <= '0;
        pass_q     <= pass_last ? '0 : pass_q + 1'b1;
      end else begin
        col_q      <= col_q + 1'b1;
        col_offs_q <= col_offs_q + TILE_JMP;
      end
      // Move to the next row tile once every W pass has swept it
      if (col_last && pass_last) begin
        row_q      <= row_last ? '0 : row_q + 1'b1;
        row_offs_q <= row_last ? '0 : row_offs_q + x_rows_offs_i;
      end
    end
  end

  assign x_offset_o   = row_offs_q + col_offs_q;
  assign tot_x_read_o = tot_q;

  // Last row tile may be partial
  assign x_reads_o = (row_last && leftover_rows_i != '0) ? cnt_t'(leftover_rows_i)
                                                         : cnt_t'(ARRAY_W);

endmodule

`default_nettype wire

/* src/job_regfile.sv */
/*
 * Job register file
 * Fourteen job words with an indexed write and readback port
 */
`timescale 1ns/1ps
`default_nettype none

module job_regfile
  import mmu_regmap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cfg_we_i,
  input  reg_idx_t    cfg_addr_i,
  input  logic [31:0] cfg_wdata_i,
  output logic [31:0] cfg_rdata_o,
  output logic [31:0] x_addr_o,
  output logic [31:0] w_addr_o,
  output logic [31:0] z_addr_o,
  output logic [31:0] x_iters_o,
  output logic [31:0] w_iters_o,
  output logic [31:0] leftovers_o,
  output logic [31:0] tot_x_read_o,
  output logic [31:0] x_rows_offs_o,
  output logic [31:0] x_d1_stride_o,
  output logic [31:0] w_tot_len_o,
  output logic [31:0] w_d0_stride_o,
  output logic [31:0] z_tot_len_o,
  output logic [31:0] z_d0_stride_o,
  output logic [31:0] op_sel_o
);

  logic [31:0] regs_q [NUM_REGS];
  logic        addr_ok;

  assign addr_ok = (cfg_addr_i < NUM_REGS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (cfg_we_i && addr_ok) begin
      regs_q[cfg_addr_i] <= cfg_wdata_i;
    end
  end

  // Unmapped indices read as zero
  assign cfg_rdata_o = addr_ok ? regs_q[cfg_addr_i] : '0;

  assign x_addr_o      = regs_q[X_ADDR];
  assign w_addr_o      = regs_q[W_ADDR];
  assign z_addr_o      = regs_q[Z_ADDR];
  assign x_iters_o     = regs_q[X_ITERS];
  assign w_iters_o     = regs_q[W_ITERS];
  assign leftovers_o   = regs_q[LEFTOVERS];
  assign tot_x_read_o  = regs_q[TOT_X_READ];
  assign x_rows_offs_o = regs_q[X_ROWS_OFFS];
  assign x_d1_stride_o = regs_q[X_D1_STRIDE];
  assign w_tot_len_o   = regs_q[W_TOT_LEN];
  assign w_d0_stride_o = regs_q[W_D0_STRIDE];
  assign z_tot_len_o   = regs_q[Z_TOT_LEN];
  assign z_d0_stride_o = regs_q[Z_D0_STRIDE];
  assign op_sel_o      = regs_q[OP_SELECTION];

endmodule

`default_nettype wire

/* src/mmu_load_unit.sv */
/*
 * Matrix-multiply load unit
 * Job registers, memory scheduler and the four stream generators
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_load_unit
  import mmu_geom_pkg::*;
  import mmu_regmap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cfg_we_i,
  input  reg_idx_t    cfg_addr_i,
  input  logic [31:0] cfg_wdata_i,
  output logic [31:0] cfg_rdata_o,
  input  logic        start_i,
  output logic        busy_o,
  output logic        done_o,
  output addr_t       x_addr_o,
  output logic        x_valid_o,
  output addr_t       w_addr_o,
  output logic        w_valid_o,
  output addr_t       y_addr_o,
  output logic        y_valid_o,
  output addr_t       z_addr_o,
  output logic        z_valid_o
);

  logic [31:0] p_x_addr, p_w_addr, p_z_addr, p_x_iters, p_w_iters, p_leftovers;
  logic [31:0] p_tot_x_read, p_x_rows_offs, p_x_d1_stride, p_w_tot_len;
  logic [31:0] p_w_d0_stride, p_z_tot_len, p_z_d0_stride, p_op_sel;

  logic  x_req, w_req, y_req, z_req;
  logic  x_rdy, w_rdy, y_rdy, z_rdy;
  logic  x_dn, w_dn, y_dn, z_dn;
  addr_t x_base, w_base, y_base, z_base;
  cnt_t  x_tot, w_tot, y_tot, z_tot;
  cnt_t  x_d0l, w_d0l, y_d0l, z_d0l;
  addr_t x_d0s, w_d0s, y_d0s, z_d0s;
  addr_t x_d1s, w_d1s, y_d1s, z_d1s;

  job_regfile i_job_regfile (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o),
    .x_addr_o(p_x_addr), .w_addr_o(p_w_addr), .z_addr_o(p_z_addr),
    .x_iters_o(p_x_iters), .w_iters_o(p_w_iters), .leftovers_o(p_leftovers),
    .tot_x_read_o(p_tot_x_read), .x_rows_offs_o(p_x_rows_offs),
    .x_d1_stride_o(p_x_d1_stride), .w_tot_len_o(p_w_tot_len),
    .w_d0_stride_o(p_w_d0_stride), .z_tot_len_o(p_z_tot_len),
    .z_d0_stride_o(p_z_d0_stride), .op_sel_o(p_op_sel)
  );

  memory_scheduler i_memory_scheduler (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .start_i(start_i), .busy_o(busy_o), .done_o(done_o),
    .x_addr_i(p_x_addr), .w_addr_i(p_w_addr), .z_addr_i(p_z_addr),
    .x_iters_i(p_x_iters), .w_iters_i(p_w_iters), .leftovers_i(p_leftovers),
    .tot_x_read_i(p_tot_x_read), .x_rows_offs_i(p_x_rows_offs),
    .x_d1_stride_i(p_x_d1_stride), .w_tot_len_i(p_w_tot_len),
    .w_d0_stride_i(p_w_d0_stride), .z_tot_len_i(p_z_tot_len),
    .z_d0_stride_i(p_z_d0_stride), .op_sel_i(p_op_sel),
    .x_ready_i(x_rdy), .w_ready_i(w_rdy), .y_ready_i(y_rdy), .z_ready_i(z_rdy),
    .x_done_i(x_dn), .w_done_i(w_dn), .y_done_i(y_dn), .z_done_i(z_dn),
    .x_req_start_o(x_req), .x_base_o(x_base), .x_tot_len_o(x_tot),
    .x_d0_len_o(x_d0l), .x_d0_stride_o(x_d0s), .x_d1_stride_o(x_d1s),
    .w_req_start_o(w_req), .w_base_o(w_base), .w_tot_len_o(w_tot),
    .w_d0_len_o(w_d0l), .w_d0_stride_o(w_d0s), .w_d1_stride_o(w_d1s),
    .y_req_start_o(y_req), .y_base_o(y_base), .y_tot_len_o(y_tot),
    .y_d0_len_o(y_d0l), .y_d0_stride_o(y_d0s), .y_d1_stride_o(y_d1s),
    .z_req_start_o(z_req), .z_base_o(z_base), .z_tot_len_o(z_tot),
    .z_d0_len_o(z_d0l), .z_d0_stride_o(z_d0s), .z_d1_stride_o(z_d1s)
  );

  stream_addr_gen i_x_source (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_start_i(x_req), .base_i(x_base),
    .tot_len_i(x_tot), .d0_len_i(x_d0l), .d0_stride_i(x_d0s), .d1_stride_i(x_d1s),
    .ready_start_o(x_rdy), .addr_o(x_addr_o), .addr_valid_o(x_valid_o), .done_o(x_dn)
  );

  stream_addr_gen i_w_source (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_start_i(w_req), .base_i(w_base),
    .tot_len_i(w_tot), .d0_len_i(w_d0l), .d0_stride_i(w_d0s), .d1_stride_i(w_d1s),
    .ready_start_o(w_rdy), .addr_o(w_addr_o), .addr_valid_o(w_valid_o), .done_o(w_dn)
  );

  stream_addr_gen i_y_source (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_start_i(y_req), .base_i(y_base),
    .tot_len_i(y_tot), .d0_len_i(y_d0l), .d0_stride_i(y_d0s), .d1_stride_i(y_d1s),
    .ready_start_o(y_rdy), .addr_o(y_addr_o), .addr_valid_o(y_valid_o), .done_o(y_dn)
  );

  stream_addr_gen i_z_sink (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_start_i(z_req), .base_i(z_base),
    .tot_len_i(z_tot), .d0_len_i(z_d0l), .d0_stride_i(z_d0s), .d1_stride_i(z_d1s),
    .ready_start_o(z_rdy), .addr_o(z_addr_o), .addr_valid_o(z_valid_o), .done_o(z_dn)
  );

endmodule

`default_nettype wire

/* src/stream_addr_gen.sv */
/*
 * Stream address generator
 * Two-level strided walk, one address per cycle
 */
`timescale 1ns/1ps
`default_nettype none

module stream_addr_gen
  import mmu_geom_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_start_i,
  input  addr_t base_i,
  input  cnt_t  tot_len_i,
  input  cnt_t  d0_len_i,
  input  addr_t d0_stride_i,
  input  addr_t d1_stride_i,
  output logic  ready_start_o,
  output addr_t addr_o,
  output logic  addr_valid_o,
  output logic  done_o
);

  logic  busy_q, done_q;
  cnt_t  left_q, idx_q, d0_len_q;
  addr_t addr_q, line_q, d0_stride_q, d1_stride_q;
  logic  fire, line_end, last;

  assign fire     = req_start_i && !busy_q;
  assign line_end = (idx_q + 1'b1 >= d0_len_q);
  assign last     = busy_q && (left_q == cnt_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      left_q <= '0;
      idx_q  <= '0;
    end else begin
      // Empty request completes at once
      done_q <= last || (fire && tot_len_i == '0);
      if (fire) begin
        busy_q <= (tot_len_i != '0);
        left_q <= tot_len_i;
        idx_q  <= '0;
      end else if (busy_q) begin
        left_q <= left_q - 1'b1;
        idx_q  <= line_end ? '0 : idx_q + 1'b1;
        if (last) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Running line base avoids a multiplier
  always_ff @(posedge clk_i) begin
    if (fire) begin
      addr_q      <= base_i;
      line_q      <= base_i;
      d0_len_q    <= d0_len_i;
      d0_stride_q <= d0_stride_i;
      d1_stride_q <= d1_stride_i;
    end else if (busy_q) begin
      if (line_end) begin
        line_q <= line_q + d1_stride_q;
        addr_q <= line_q + d1_stride_q;
      end else begin
        addr_q <= addr_q + d0_stride_q;
      end
    end
  end

  assign ready_start_o = !busy_q;
  assign addr_o        = addr_q;
  assign addr_valid_o  = busy_q;
  assign done_o        = done_q;

endmodule

`default_nettype wire

/* tb/mmu_ref_model.svh */
/*
 * Reference model of the load unit schedule
 * Builds the expected address list of every stream for one job
 */
`ifndef MMU_REF_MODEL_SVH
`define MMU_REF_MODEL_SVH

// Address n of a two-level walk with the inner index first
function automatic addr_t stream_addr(input addr_t base, input cnt_t d0_len,
                                      input addr_t d0_stride, input addr_t d1_stride,
                                      input int unsigned n);
  int unsigned i;
  int unsigned j;
  i = n % int'(d0_len);
  j = n / int'(d0_len);
  return base + addr_t'(j) * d1_stride + addr_t'(i) * d0_stride;
endfunction

// Row tile of burst k in column, W-pass and row order
function automatic int unsigned burst_row(input cnt_t cols, input cnt_t passes,
                                          input cnt_t rows, input int unsigned k);
  return (k / (int'(cols) * int'(passes))) % int'(rows);
endfunction

function automatic addr_t x_burst_base(input addr_t x_addr, input cnt_t cols,
                                       input cnt_t passes, input cnt_t rows,
                                       input addr_t rows_offs, input int unsigned k);
  int unsigned col;
  col = k % int'(cols);
  return x_addr + addr_t'(burst_row(cols, passes, rows, k)) * rows_offs
         + addr_t'(col) * TILE_JMP;
endfunction

function automatic cnt_t x_burst_len(input cnt_t cols, input cnt_t passes, input cnt_t rows,
                                     input logic [7:0] left, input int unsigned k);
  if (burst_row(cols, passes, rows, k) == int'(rows) - 1 && left != 8'd0) begin
    return cnt_t'(left);
  end
  return cnt_t'(ARRAY_W);
endfunction

task automatic build_expected();
  cnt_t        cols, rows, passes, len, w_tot, z_tot;
  addr_t       base;
  int unsigned k, n;
  cols   = job_words[X_ITERS][ITERS_LO_LSB +: 16];
  rows   = job_words[X_ITERS][ITERS_HI_LSB +: 16];
  passes = job_words[W_ITERS][ITERS_LO_LSB +: 16];
  w_tot  = job_words[W_TOT_LEN][15:0];
  z_tot  = job_words[Z_TOT_LEN][15:0];
  exp_bursts = job_words[TOT_X_READ][15:0] + 1'b1;
  exp_total  = 0;
  for (k = 0; k < exp_bursts; k++) begin
    base = x_burst_base(job_words[X_ADDR], cols, passes, rows, job_words[X_ROWS_OFFS], k);
    len  = x_burst_len(cols, passes, rows, job_words[LEFTOVERS][31:24], k);
    exp_xlen.push_back(len);
    for (n = 0; n < len; n++) begin
      exp_x.push_back(stream_addr(base, cnt_t'(1), '0, job_words[X_D1_STRIDE], n));
    end
    exp_total += len;
  end
  for (n = 0; n < w_tot; n++) begin
    exp_w.push_back(stream_addr(job_words[W_ADDR], job_words[W_ITERS][31:16],
                                job_words[W_D0_STRIDE], TILE_JMP, n));
  end
  for (n = 0; n < z_tot; n++) begin
    exp_z.push_back(stream_addr(job_words[Z_ADDR], cnt_t'(ARRAY_W),
                                job_words[Z_D0_STRIDE], TILE_JMP, n));
    if (job_words[OP_SELECTION][0]) begin
      exp_y.push_back(exp_z[exp_z.size() - 1]);
    end
  end
  exp_total += w_tot + z_tot;
endtask

`endif

/* tb/tb_mmu_load_unit.sv */
/*
 * Testbench of the matrix-multiply load unit
 * Directed and random jobs checked against the reference schedule
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mmu_load_unit
  import mmu_geom_pkg::*;
  import mmu_regmap_pkg::*;
;

  localparam logic [31:0] SEED = 32'hab2b3702;
  localparam int unsigned RANDOM_JOBS = 8;

  logic        clk_i, rst_ni, cfg_we_i, start_i, busy_o, done_o;
  reg_idx_t    cfg_addr_i;
  logic [31:0] cfg_wdata_i, cfg_rdata_o;
  addr_t       x_addr_o, w_addr_o, y_addr_o, z_addr_o;
  logic        x_valid_o, w_valid_o, y_valid_o, z_valid_o;

  logic [31:0] job_words [NUM_REGS];
  addr_t       exp_x[$], exp_w[$], exp_y[$], exp_z[$];
  cnt_t        exp_xlen[$];
  cnt_t        exp_bursts;
  int unsigned exp_total;

  logic [31:0] rng_state;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 200;
  int unsigned done_seen = 0;
  int unsigned x_bursts = 0;
  int unsigned x_run_len = 0;
  logic        x_valid_q = 1'b0;

  `include "mmu_ref_model.svh"

  mmu_load_unit mmu_load_unit_inst (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o),
    .start_i(start_i), .busy_o(busy_o), .done_o(done_o),
    .x_addr_o(x_addr_o), .x_valid_o(x_valid_o), .w_addr_o(w_addr_o), .w_valid_o(w_valid_o),
    .y_addr_o(y_addr_o), .y_valid_o(y_valid_o), .z_addr_o(z_addr_o), .z_valid_o(z_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input cnt_t got, input cnt_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    return lo + rand_word() % (hi - lo + 1);
  endfunction

  // Sampling and comparison of every stream
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (x_valid_o) begin
        if (exp_x.size() == 0) begin
          abort_run("An X address came out although none was expected");
        end else begin
          check_addr(x_addr_o, exp_x.pop_front(), "X address");
          x_run_len++;
        end
      end else if (x_valid_q) begin
        if (exp_xlen.size() == 0) begin
          abort_run("An X burst ended although no more bursts were expected");
        end else begin
          check_count(cnt_t'(x_run_len), exp_xlen.pop_front(), "X burst length");
          x_run_len = 0;
          x_bursts++;
        end
      end
      x_valid_q = x_valid_o;
      if (w_valid_o) begin
        if (exp_w.size() == 0) begin
          abort_run("A W address came out although none was expected");
        end else begin
          check_addr(w_addr_o, exp_w.pop_front(), "W address");
        end
      end
      if (y_valid_o) begin
        if (exp_y.size() == 0) begin
          abort_run("A Y address came out although the Y load was not expected");
        end else begin
          check_addr(y_addr_o, exp_y.pop_front(), "Y address");
        end
      end
      if (z_valid_o) begin
        if (exp_z.size() == 0) begin
          abort_run("A Z address came out although none was expected");
        end else begin
          check_addr(z_addr_o, exp_z.pop_front(), "Z address");
        end
      end
      if (done_o) begin
        done_seen++;
        check_count(cnt_t'(x_bursts), exp_bursts, "X bursts in job");
        check_count(cnt_t'(exp_x.size() + exp_w.size() + exp_y.size() + exp_z.size()),
                    cnt_t'(0), "addresses still missing at done");
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("Timeout: the job did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic write_reg(input reg_idx_t idx, input logic [31:0] data);
    @(negedge clk_i);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = idx;
    cfg_wdata_i = data;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
  endtask

  task automatic test_registers();
    logic [31:0] pattern [16];
    int          r;
    for (r = 0; r < 16; r++) begin
      pattern[r] = rand_word();
      write_reg(reg_idx_t'(r), pattern[r]);
    end
    for (r = 0; r < 16; r++) begin
      @(negedge clk_i);
      cfg_addr_i = reg_idx_t'(r);
      @(posedge clk_i);
      if (r < NUM_REGS) begin
        check_word(cfg_rdata_o, pattern[r], "register readback");
      end else begin
        check_word(cfg_rdata_o, 32'h0, "unmapped register readback");
      end
    end
  endtask

  task automatic set_job(input int unsigned cols, input int unsigned rows,
                         input int unsigned passes, input int unsigned w_d0,
                         input int unsigned left, input int unsigned w_tot,
                         input int unsigned z_tot, input logic y_on);
    job_words[X_ADDR]       = rand_word() & 32'hffff_ffc0;
    job_words[W_ADDR]       = rand_word() & 32'hffff_ffc0;
    job_words[Z_ADDR]       = rand_word() & 32'hffff_ffc0;
    job_words[X_ITERS]      = (rows << 16) | cols;
    job_words[W_ITERS]      = (w_d0 << 16) | passes;
    job_words[LEFTOVERS]    = left << 24;
    job_words[TOT_X_READ]   = cols * rows * passes - 1;
    job_words[X_ROWS_OFFS]  = rand_range(1, 16) << 8;
    job_words[X_D1_STRIDE]  = rand_range(1, 8) << 4;
    job_words[W_TOT_LEN]    = w_tot;
    job_words[W_D0_STRIDE]  = rand_range(1, 8) << 2;
    job_words[Z_TOT_LEN]    = z_tot;
    job_words[Z_D0_STRIDE]  = rand_range(1, 8) << 2;
    job_words[OP_SELECTION] = {31'b0, y_on};
  endtask

  task automatic random_job();
    int unsigned cols, rows, passes, w_d0, left, w_tot, z_tot, y_on;
    cols   = rand_range(1, 4);
    rows   = rand_range(1, 3);
    passes = rand_range(1, 3);
    w_d0   = rand_range(1, 8);
    left   = rand_range(0, 7);
    w_tot  = rand_range(1, 32);
    z_tot  = rand_range(1, 32);
    y_on   = rand_range(0, 1);
    set_job(cols, rows, passes, w_d0, left, w_tot, z_tot, y_on[0]);
  endtask

  task automatic run_job();
    int unsigned done_before;
    int          r;
    build_expected();
    cycle_limit += 4 * exp_total + 50 + 2 * NUM_REGS;
    for (r = 0; r < NUM_REGS; r++) begin
      write_reg(reg_idx_t'(r), job_words[r]);
    end
    x_bursts    = 0;
    done_before = done_seen;
    @(negedge clk_i);
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    check_word({31'b0, busy_o}, 32'h1, "busy after start");
    while (done_seen == done_before) begin
      @(negedge clk_i);
    end
    repeat (3) @(negedge clk_i);
    check_count(cnt_t'(done_seen - done_before), cnt_t'(1), "done pulses in job");
    check_word({31'b0, busy_o}, 32'h0, "busy after done");
  endtask

  initial begin
    rst_ni      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    start_i     = 1'b0;
    rng_state   = SEED;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_word({31'b0, busy_o}, 32'h0, "busy after reset");
    check_word({27'b0, done_o, x_valid_o, w_valid_o, y_valid_o, z_valid_o}, 32'h0,
               "outputs after reset");
    test_registers();
    // Full row tiles without the Y load
    set_job(3, 2, 2, 4, 0, 16, 16, 1'b0);
    run_job();
    // Partial last row tile with the Y load on
    set_job(2, 3, 1, 8, 5, 24, 16, 1'b1);
    run_job();
    for (int j = 0; j < RANDOM_JOBS; j++) begin
      random_job();
      run_job();
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
